// ==== build.f ====
hdl/bpf_pkg.sv
hdl/bpf_alu.sv
hdl/bpf_scratch.sv
hdl/bpf_datapath.sv
hdl/bpf_controller.sv
hdl/bpf_core.sv
tests/bpf_core_checker.sv
tests/bpf_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the BPF core testbench, the log decides the verdict
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f build.f --top-module bpf_core_tb -o sim_bpf \
    && ./obj_dir/sim_bpf > sim.log 2>&1 \
    || echo "Some tests failed" >> sim.log
cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0

// ==== tests/bpf_core_tb.sv ====
`timescale 1ns/1ps

module bpf_core_tb import bpf_pkg::*; ();

    logic       clk = 1'b0;
    logic       rst;
    logic       start;
    pkt_len_t   packet_len;
    code_addr_t code_addr;
    bpf_insn_t  code_data = '0;
    pkt_addr_t  pkt_addr;
    word_t      pkt_data = '0;
    logic       busy;
    logic       done;
    logic       accept;
    word_t      ret_val;

    bpf_insn_t  code_mem [256];
    logic [7:0] pkt_mem [4096];
    word_t      ref_mem [16];   // Scratch state carried across runs
    logic [31:0] lfsr_state;
    int         prog_len;
    int         cycles;
    int         budget;
    int         errors;
    int         runs_started;
    int         done_cnt;
    logic       in_run;         // Start taken, done not yet seen
    word_t      exp_ret;
    logic [3:0] alu_ops [9] = '{4'h0, 4'h1, 4'h2, 4'h4, 4'h5, 4'h6, 4'h7, 4'h8, 4'ha};

    bpf_core u_bpf_core (
        .clk(clk), .rst(rst), .start(start), .packet_len(packet_len),
        .code_addr(code_addr), .code_data(code_data), .pkt_addr(pkt_addr),
        .pkt_data(pkt_data), .busy(busy), .done(done), .accept(accept), .ret_val(ret_val)
    );

    bind bpf_controller bpf_core_checker u_chk (
        .clk(clk), .rst(rst), .busy(busy), .done(done), .state(state)
    );

    always #4 clk = ~clk;

    // Registered memories, one cycle read latency
    always @(posedge clk) begin
        code_data <= code_mem[code_addr];
        pkt_data  <= {pkt_mem[pkt_addr], pkt_mem[{pkt_addr[11:2], 2'd1}],
                      pkt_mem[{pkt_addr[11:2], 2'd2}], pkt_mem[{pkt_addr[11:2], 2'd3}]};
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]}; // One step per bit
        end
        return v;
    endfunction

    function automatic word_t pkt_read(input logic [11:0] addr, input int nb);
        word_t v;
        v = '0;
        for (int i = 0; i < nb; i++) begin
            v = {v[23:0], pkt_mem[addr + 12'(i)]}; // Big-endian
        end
        return v;
    endfunction

    // Classic BPF interpreter over code_mem and pkt_mem
    function automatic word_t ref_run(input pkt_len_t len);
        bpf_insn_t  in;
        word_t      a;
        word_t      x;
        word_t      b;
        code_addr_t pc;
        code_addr_t nx;
        logic [63:0] ea;
        int         nb;
        logic       taken;
        a = '0;
        x = '0;
        pc = '0;
        for (int step = 0; step < 256; step++) begin
            in = code_mem[pc];
            nx = pc + 8'd1;
            b = in.code[3] ? x : in.k;
            if (in.code[15:8] != 8'h00) return '0;
            casez (in.code[7:0])
                8'h00: a = in.k;
                8'h80: a = word_t'(len);
                8'h60: a = ref_mem[in.k[3:0]];
                8'h20, 8'h28, 8'h30, 8'h40, 8'h48, 8'h50: begin
                    nb = (in.code[4:3] == 2'h0) ? 4 : (in.code[4:3] == 2'h1) ? 2 : 1;
                    ea = 64'(in.k) + (in.code[6] ? 64'(x) : 64'h0); // Indirect adds X
                    if (ea + 64'(nb) > 64'(len)) return '0;
                    a = pkt_read(ea[11:0], nb);
                end
                8'h01: x = in.k;
                8'h81: x = word_t'(len);
                8'h61: x = ref_mem[in.k[3:0]];
                8'hb1: begin
                    ea = 64'(in.k);
                    if (ea + 64'h1 > 64'(len)) return '0;
                    x = {26'h0, pkt_mem[ea[11:0]][3:0], 2'b00};
                end
                8'h02: ref_mem[in.k[3:0]] = a;
                8'h03: ref_mem[in.k[3:0]] = x;
                8'h06: return in.k;
                8'h16: return a;
                8'h07: x = a;
                8'h87: a = x;
                8'b????_?100: begin
                    case (in.code[7:4])
                        4'h0: a = a + b;
                        4'h1: a = a - b;
                        4'h2: a = a * b;
                        4'h4: a = a | b;
                        4'h5: a = a & b;
                        4'h6: a = a << b; // Counts of 32 and up give 0
                        4'h7: a = a >> b;
                        4'h8: if (in.code[3]) return '0; else a = -a;
                        4'ha: a = a ^ b;
                        default: return '0;
                    endcase
                end
                8'b????_?101: begin
                    case (in.code[7:4])
                        4'h0: if (in.code[3]) return '0; else nx = nx + in.k[7:0];
                        4'h1: taken = (a == b);
                        4'h2: taken = (a > b);
                        4'h3: taken = (a >= b);
                        4'h4: taken = ((a & b) != 0);
                        default: return '0;
                    endcase
                    if (in.code[7:4] != 4'h0) nx = nx + (taken ? in.jt : in.jf);
                end
                default: return '0; // Unknown opcode aborts
            endcase
            pc = nx;
        end
        return '0;
    endfunction

    task automatic fail_stop(input string msg);
        $display("%s (time %0t)", msg, $time);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic compare_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            fail_stop("Wrong value from the DUT");
        end
    endtask

    task automatic compare_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
            fail_stop("Wrong flag from the DUT");
        end
    endtask

    // Checks busy every cycle and every done pulse against the reference
    always @(negedge clk) begin
        if (!rst) begin
            compare_bit("busy", busy, in_run && !done); // Low again in the done cycle
        end
        if (!rst && done) begin
            if (done_cnt >= runs_started) fail_stop("done pulse without a started run");
            compare_word("ret_val", ret_val, exp_ret);
            compare_bit("accept", accept, exp_ret != '0);
            done_cnt++;
            in_run = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > budget) fail_stop("Timeout, the DUT never finished its program");
    end

    task automatic put(input logic [15:0] c, input logic [7:0] jt, input logic [7:0] jf,
                       input word_t k);
        code_mem[prog_len[7:0]] = '{code: c, jt: jt, jf: jf, k: k};
        prog_len++;
    endtask

    task automatic run_prog(input logic extra_start);
        pkt_len_t len;
        len = 13'(64 + rand_bits(6));
        exp_ret = ref_run(len);
        budget += 40 * prog_len;
        runs_started++;
        @(posedge clk);
        #1 packet_len = len;
        start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        in_run = 1'b1;
        if (extra_start) begin
            repeat (9) @(posedge clk); // Mid-program, past the early stores
            #1;
            if (busy) begin // Must be ignored
                start = 1'b1;
                @(posedge clk);
                #1 start = 1'b0;
            end
        end
        wait (done_cnt == runs_started);
        prog_len = 0;
    endtask

    task automatic load_tests();
        logic [1:0] sz;
        word_t      off;
        for (int f = 0; f < 6; f++) begin
            sz = 2'(f % 3);
            off = (rand_bits(3) << 2) + (rand_bits(2) & ((sz == 2'h0) ? 32'd0 :
                  (sz == 2'h1) ? 32'd2 : 32'd3)); // Aligned to the size
            put(16'h0001, 8'd0, 8'd0, rand_bits(3) << 2);
            put(16'({(f < 3) ? 3'h1 : 3'h2, sz, 3'h0}), 8'd0, 8'd0, off);
            put(16'h0016, 8'd0, 8'd0, 32'd0);
            run_prog(1'b0);
        end
        put(16'h0000, 8'd0, 8'd0, rand_bits(32));
        put(16'h0016, 8'd0, 8'd0, 32'd0);
        run_prog(1'b0);
        put(16'h0080, 8'd0, 8'd0, 32'd0);
        put(16'h0016, 8'd0, 8'd0, 32'd0);
        run_prog(1'b0);
        for (int f = 0; f < 3; f++) begin // ldx imm, len, msh
            put((f == 0) ? 16'h0001 : (f == 1) ? 16'h0081 : 16'h00b1, 8'd0, 8'd0,
                (f == 0) ? rand_bits(32) : rand_bits(6));
            put(16'h0087, 8'd0, 8'd0, 32'd0);
            put(16'h0016, 8'd0, 8'd0, 32'd0);
            run_prog(1'b0);
        end
    endtask

    task automatic alu_jump_tests();
        word_t a;
        word_t b;
        word_t c;
        for (int i = 0; i < 9; i++) begin
            for (int s = 0; s < 2; s++) begin
                if (alu_ops[i] == 4'h8 && s == 1) continue; // No neg with X
                b = (alu_ops[i] inside {4'h6, 4'h7}) ? rand_bits(6) : rand_bits(32);
                c = rand_bits(32); // Operand the op must not pick
                put(16'h0000, 8'd0, 8'd0, rand_bits(32));
                put(16'h0001, 8'd0, 8'd0, s[0] ? b : c);
                put(16'({alu_ops[i], s[0], 3'h4}), 8'd0, 8'd0, s[0] ? c : b);
                put(16'h0016, 8'd0, 8'd0, 32'd0);
                run_prog(1'b0);
            end
        end
        for (int j = 1; j < 5; j++) begin
            for (int s = 0; s < 2; s++) begin
                for (int v = 0; v < 4; v++) begin
                    a = rand_bits(32);
                    b = (v == 0) ? a : (v == 1) ? a + 32'd1 : (v == 2) ? a - 32'd1 : ~a;
                    c = rand_bits(32); // Unused source
                    put(16'h0000, 8'd0, 8'd0, a);
                    put(16'h0001, 8'd0, 8'd0, s[0] ? b : c);
                    put(16'({4'(j), s[0], 3'h5}), 8'd1, 8'd0, s[0] ? c : b);
                    put(16'h0006, 8'd0, 8'd0, 32'd0);  // Not taken, rejects
                    put(16'h0006, 8'd0, 8'd0, rand_bits(32) | 32'd1);
                    run_prog(1'b0);
                end
            end
        end
        put(16'h0005, 8'd0, 8'd0, 32'd1); // ja over a reject
        put(16'h0006, 8'd0, 8'd0, 32'd0);
        put(16'h0006, 8'd0, 8'd0, 32'h5a);
        run_prog(1'b0);
    endtask

    task automatic scratch_abort_tests();
        put(16'h0000, 8'd0, 8'd0, rand_bits(32));
        put(16'h0002, 8'd0, 8'd0, 32'd5);
        put(16'h0001, 8'd0, 8'd0, rand_bits(32));
        put(16'h0003, 8'd0, 8'd0, 32'd9);
        put(16'h0061, 8'd0, 8'd0, 32'd5);
        put(16'h0060, 8'd0, 8'd0, 32'd9);
        put(16'h000c, 8'd0, 8'd0, 32'd0);  // add X
        put(16'h0007, 8'd0, 8'd0, 32'd0);
        put(16'h0087, 8'd0, 8'd0, 32'd0);
        put(16'h0016, 8'd0, 8'd0, 32'd0);
        run_prog(1'b0);
        put(16'h0060, 8'd0, 8'd0, 32'd5);  // Carried from the last run
        put(16'h0016, 8'd0, 8'd0, 32'd0);
        run_prog(1'b0);
        put(16'h000c, 8'd0, 8'd0, 32'd0);  // A and X cleared by start
        put(16'h0016, 8'd0, 8'd0, 32'd0);
        run_prog(1'b0);
        put(16'h0060, 8'd0, 8'd0, 32'd14); // Counter in M[14]
        put(16'h0004, 8'd0, 8'd0, 32'd1);
        put(16'h0002, 8'd0, 8'd0, 32'd14); // A restart would count twice
        for (int i = 0; i < 6; i++) put(16'h0001, 8'd0, 8'd0, 32'd0);
        put(16'h0016, 8'd0, 8'd0, 32'd0);
        run_prog(1'b1);
        put(16'h0020, 8'd0, 8'd0, 32'd128); // Past any packet_len used
        put(16'h0006, 8'd0, 8'd0, 32'd1);
        run_prog(1'b0);
        put(16'h0001, 8'd0, 8'd0, 32'hfffffffc); // X+k carries out
        put(16'h0040, 8'd0, 8'd0, 32'd8);
        put(16'h0006, 8'd0, 8'd0, 32'd1);
        run_prog(1'b0);
        put(16'h0000, 8'd0, 8'd0, 32'd5);
        put(16'h00ff, 8'd0, 8'd0, 32'd0);  // Unknown opcode
        put(16'h0006, 8'd0, 8'd0, 32'd7);
        run_prog(1'b0);
    endtask

    task automatic random_program(input int n);
        int    r;
        int    pick;
        word_t k;
        for (int i = 0; i < n - 1; i++) begin
            pick = int'(rand_bits(4));
            r = n - 2 - i; // Forward jumps stay inside the program
            k = rand_bits(32);
            case (pick)
                0, 1:    put(16'h0000, 8'd0, 8'd0, k);
                2:       put(16'h0020, 8'd0, 8'd0, rand_bits(5) << 2);
                3:       put(16'h0050, 8'd0, 8'd0, rand_bits(5));
                4:       put(16'h0001, 8'd0, 8'd0, rand_bits(4) << 2);
                5, 6, 7: begin
                    pick = int'(rand_bits(4)) % 9;
                    put(16'({alu_ops[pick], (alu_ops[pick] != 4'h8) & k[31], 3'h4}),
                        8'd0, 8'd0, (alu_ops[pick] inside {4'h6, 4'h7}) ? rand_bits(6) : k);
                end
                8:       put(16'h0002, 8'd0, 8'd0, rand_bits(4));
                9:       put(16'h0003, 8'd0, 8'd0, rand_bits(4));
                10:      put(16'h0060, 8'd0, 8'd0, rand_bits(4));
                11:      put(16'h0061, 8'd0, 8'd0, rand_bits(4));
                12:      put(16'h0007, 8'd0, 8'd0, 32'd0);
                13:      put(16'h0087, 8'd0, 8'd0, 32'd0);
                default: put(16'({4'(rand_bits(2) + 32'd1), k[0], 3'h5}),
                             8'(int'(rand_bits(3)) % (r + 1)),
                             8'(int'(rand_bits(3)) % (r + 1)), k);
            endcase
        end
        put(16'h0016, 8'd0, 8'd0, 32'd0);
    endtask

    initial begin
        rst = 1'b1;
        start = 1'b0;
        packet_len = '0;
        lfsr_state = 32'h8bc392e1;
        budget = 40;
        cycles = 0;
        errors = 0;
        runs_started = 0;
        done_cnt = 0;
        in_run = 1'b0;
        prog_len = 0;
        exp_ret = '0;
        for (int i = 0; i < 16; i++) ref_mem[i] = '0;
        for (int i = 0; i < 256; i++) code_mem[i] = '0;
        for (int i = 0; i < 4096; i++) pkt_mem[i] = 8'(rand_bits(8));
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        load_tests();
        alu_jump_tests();
        scratch_abort_tests();
        for (int t = 0; t < 40; t++) begin // Back to back, some with a stray start
            random_program(4 + int'(rand_bits(3)));
            run_prog(rand_bits(1) != 0);
        end
        repeat (3) @(posedge clk);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== tests/bpf_core_checker.sv ====
`timescale 1ns/1ps

module bpf_core_checker import bpf_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       busy,
    input logic       done,
    input ctl_state_e state
);

    // done is a single-cycle pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    // Run in progress and end of run never overlap
    busy_done_excl: assert property (@(posedge clk) disable iff (rst)
        !(busy && done))
        else $error("busy and done high in the same cycle");

    done_to_idle: assert property (@(posedge clk) disable iff (rst)
        done |=> (state == IDLE)) // Back to waiting for start
        else $error("controller did not return to IDLE after done");

    // Only the six encoded states are legal
    state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {IDLE, FETCH, DECODE, PKT_WAIT, ALU_WAIT, DONE})
        else $error("controller state left the state enum");

endmodule

// ==== hdl/bpf_core.sv ====
`timescale 1ns/1ps

module bpf_core import bpf_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  pkt_len_t   packet_len,
    output code_addr_t code_addr,
    input  bpf_insn_t  code_data,
    output pkt_addr_t  pkt_addr,
    input  word_t      pkt_data,
    output logic       busy,
    output logic       done,
    output logic       accept,
    output word_t      ret_val
);

    dp_ctl_t    dp_ctl;
    dp_stat_t   dp_stat;
    word_t      insn_k;
    logic [7:0] insn_jt;
    logic [7:0] insn_jf;

    bpf_controller u_ctl (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .code_data (code_data),
        .dp_stat   (dp_stat),
        .dp_ctl    (dp_ctl),
        .insn_k    (insn_k),
        .insn_jt   (insn_jt),
        .insn_jf   (insn_jf),
        .busy      (busy),
        .done      (done),
        .accept    (accept),
        .ret_val   (ret_val)
    );

    bpf_datapath u_dp (
        .clk        (clk),
        .rst        (rst),
        .dp_ctl     (dp_ctl),
        .insn_k     (insn_k),
        .insn_jt    (insn_jt),
        .insn_jf    (insn_jf),
        .packet_len (packet_len),
        .pkt_data   (pkt_data),
        .pc         (code_addr), // PC drives the code memory directly
        .pkt_addr   (pkt_addr),
        .dp_stat    (dp_stat)
    );

endmodule

// ==== hdl/bpf_controller.sv ====
`timescale 1ns/1ps

module bpf_controller import bpf_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  bpf_insn_t  code_data,
    input  dp_stat_t   dp_stat,
    output dp_ctl_t    dp_ctl,
    output word_t      insn_k,
    output logic [7:0] insn_jt,
    output logic [7:0] insn_jf,
    output logic       busy,
    output logic       done,
    output logic       accept,
    output word_t      ret_val
);

    ctl_state_e state;
    ctl_state_e state_nx;
    bpf_insn_t  insn_q;
    bpf_insn_t  cur;
    logic [2:0] cls;
    logic [1:0] sz;
    logic [2:0] mode;
    logic [3:0] op;
    logic [1:0] rval;
    logic       src;
    logic       legal;
    logic       pkt_ld;
    logic       cond_jmp;
    logic       misc_txa;
    logic       jmp_take;
    word_t      ret_d;

    // Live memory word in DECODE, latched copy afterwards
    assign cur     = (state == DECODE) ? code_data : insn_q;
    assign insn_k  = cur.k;
    assign insn_jt = cur.jt;
    assign insn_jf = cur.jf;

    assign cls  = cur.code[2:0];
    assign sz   = cur.code[4:3];
    assign rval = cur.code[4:3];
    assign src  = cur.code[3];
    assign mode = cur.code[7:5];
    assign op   = cur.code[7:4];

    assign pkt_ld = ((cls == CLS_LD) && (mode inside {MODE_ABS, MODE_IND}))
                 || ((cls == CLS_LDX) && (mode == MODE_MSH));
    assign cond_jmp = (cls == CLS_JMP) && (op != JMP_JA);
    assign misc_txa = (cur.code[7:3] == MISC_TXA);

    // Opcode check, anything else aborts with 0
    always_comb begin
        legal = 1'b0;
        if (cur.code[15:8] == 8'h00) begin
            case (cls)
                CLS_LD: legal = (mode inside {MODE_ABS, MODE_IND}) ? (sz != 2'h3)
                              : ((mode inside {MODE_IMM, MODE_MEM, MODE_LEN}) && sz == SZ_W);
                CLS_LDX: legal = (mode == MODE_MSH) ? (sz == SZ_B)
                               : ((mode inside {MODE_IMM, MODE_MEM, MODE_LEN}) && sz == SZ_W);
                CLS_ST, CLS_STX: legal = (cur.code[7:3] == 5'h00);
                CLS_ALU: legal = (op inside {ADD, SUB, MUL, OR, AND, XOR, LSH, RSH})
                               || (op == NEG && src == SRC_K);
                CLS_JMP: legal = (op == JMP_JA) ? (src == SRC_K) : (op <= JMP_JSET);
                CLS_RET: legal = (cur.code[7:5] == 3'h0) && (rval inside {RVAL_K, RVAL_A});
                default: legal = (cur.code[7:3] inside {MISC_TAX, MISC_TXA});
            endcase
        end
    end

    // Flag named by the jump op
    always_comb begin
        case (op)
            JMP_JEQ: jmp_take = dp_stat.eq;
            JMP_JGT: jmp_take = dp_stat.gt;
            JMP_JGE: jmp_take = dp_stat.ge;
            default: jmp_take = dp_stat.set; // jset
        endcase
    end

    assign ret_d = (legal && cls == CLS_RET)
                 ? ((rval == RVAL_A) ? dp_stat.a_value : cur.k) : '0;

    always_comb begin
        dp_ctl           = '0;
        dp_ctl.b_sel_x   = (src == SRC_X);
        dp_ctl.alu_op    = alu_op_e'(op);
        dp_ctl.st_from_x = (cls == CLS_STX);
        dp_ctl.addr_ind  = (cls == CLS_LD) && (mode == MODE_IND);
        dp_ctl.load_size = sz;
        case (mode) // Load sources, IMM by default
            MODE_ABS, MODE_IND: dp_ctl.a_sel = A_PKT;
            MODE_MEM: begin
                dp_ctl.a_sel = A_MEM;
                dp_ctl.x_sel = X_MEM;
            end
            MODE_LEN: begin
                dp_ctl.a_sel = A_LEN;
                dp_ctl.x_sel = X_LEN;
            end
            MODE_MSH: dp_ctl.x_sel = X_MSH;
            default:  dp_ctl.a_sel = A_IMM;
        endcase
        if (cls == CLS_ALU) begin
            dp_ctl.a_sel = A_ALU;
        end else if (cls == CLS_MISC) begin
            dp_ctl.a_sel = A_X;
            dp_ctl.x_sel = X_A;
        end

        state_nx = state;
        case (state)
            IDLE: begin
                if (start) begin // New run, A X PC cleared
                    dp_ctl.pc_clr   = 1'b1;
                    dp_ctl.regs_clr = 1'b1;
                    state_nx        = FETCH;
                end
            end
            FETCH: state_nx = DECODE; // Code memory answers next cycle
            DECODE: begin
                if (!legal || cls == CLS_RET) begin
                    state_nx = DONE;
                end else if (pkt_ld) begin
                    dp_ctl.pc_en = !dp_stat.oob;
                    state_nx     = dp_stat.oob ? DONE : PKT_WAIT;
                end else begin
                    dp_ctl.pc_en  = !cond_jmp; // Cond jumps step after the compare
                    dp_ctl.pc_sel = (cls == CLS_JMP) ? PC_K : PC_NEXT;
                    dp_ctl.alu_en = (cls == CLS_ALU) || cond_jmp;
                    dp_ctl.a_en   = (cls == CLS_LD) || (cls == CLS_MISC && misc_txa);
                    dp_ctl.x_en   = (cls == CLS_LDX) || (cls == CLS_MISC && !misc_txa);
                    dp_ctl.st_en  = (cls == CLS_ST) || (cls == CLS_STX);
                    state_nx      = dp_ctl.alu_en ? ALU_WAIT : FETCH;
                end
            end
            PKT_WAIT: begin
                dp_ctl.a_en = (cls == CLS_LD);
                dp_ctl.x_en = (cls == CLS_LDX);
                state_nx    = FETCH;
            end
            ALU_WAIT: begin
                if (dp_stat.alu_vld) begin
                    dp_ctl.a_en   = (cls == CLS_ALU);
                    dp_ctl.pc_en  = cond_jmp;
                    dp_ctl.pc_sel = jmp_take ? PC_JT : PC_JF;
                    state_nx      = FETCH;
                end
            end
            default: state_nx = IDLE; // DONE lasts one cycle
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            ret_val <= '0;
            accept  <= 1'b0;
        end else begin
            state <= state_nx;
            if (state == DECODE && state_nx == DONE) begin // ret or abort
                ret_val <= ret_d;
                accept  <= |ret_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            insn_q <= code_data;
        end
    end

    assign busy = state inside {FETCH, DECODE, PKT_WAIT, ALU_WAIT};
    assign done = (state == DONE);

endmodule

// ==== hdl/bpf_datapath.sv ====
`timescale 1ns/1ps

module bpf_datapath import bpf_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  dp_ctl_t    dp_ctl,
    input  word_t      insn_k,
    input  logic [7:0] insn_jt,
    input  logic [7:0] insn_jf,
    input  pkt_len_t   packet_len,
    input  word_t      pkt_data,
    output code_addr_t pc,
    output pkt_addr_t  pkt_addr,
    output dp_stat_t   dp_stat
);

    word_t       a_reg;
    word_t       x_reg;
    word_t       alu_b;
    word_t       alu_res;
    word_t       mem_rdata;
    word_t       pkt_val;
    word_t       len_word;
    logic [32:0] byte_addr;  // Carry bit kept so X+k cannot wrap into range
    logic [33:0] end_addr;
    logic [2:0]  size_bytes;
    logic        alu_eq;
    logic        alu_gt;
    logic        alu_ge;
    logic        alu_set;
    logic        alu_vld;
    code_addr_t  pc_inc;

    assign byte_addr = {1'b0, (dp_ctl.addr_ind ? x_reg : 32'd0)} + {1'b0, insn_k};
    assign pkt_addr  = {byte_addr[PKT_ADDR_W-1:2], 2'b00}; // Word aligned fetch

    always_comb begin
        case (dp_ctl.load_size)
            SZ_W:    size_bytes = 3'd4;
            SZ_H:    size_bytes = 3'd2;
            default: size_bytes = 3'd1;
        endcase
    end

    // Last byte must sit below packet_len
    assign end_addr = {1'b0, byte_addr} + 34'(size_bytes);

    // Big-endian lanes, byte 0 on bits 31:24
    always_comb begin
        case (dp_ctl.load_size)
            SZ_W:    pkt_val = pkt_data;
            SZ_H:    pkt_val = {16'h0, (byte_addr[1] ? pkt_data[15:0] : pkt_data[31:16])};
            default: pkt_val = {24'h0, pkt_data[{~byte_addr[1:0], 3'b000} +: 8]};
        endcase
    end

    assign len_word = word_t'(packet_len);

    // Accumulator and index
    always_ff @(posedge clk) begin
        if (rst || dp_ctl.regs_clr) begin
            a_reg <= '0;
            x_reg <= '0;
        end else begin
            if (dp_ctl.a_en) begin
                case (dp_ctl.a_sel)
                    A_IMM:   a_reg <= insn_k;
                    A_PKT:   a_reg <= pkt_val;
                    A_MEM:   a_reg <= mem_rdata;
                    A_LEN:   a_reg <= len_word;
                    A_ALU:   a_reg <= alu_res;
                    default: a_reg <= x_reg; // txa
                endcase
            end
            if (dp_ctl.x_en) begin
                case (dp_ctl.x_sel)
                    X_IMM:   x_reg <= insn_k;
                    X_PKT:   x_reg <= pkt_val;
                    X_MEM:   x_reg <= mem_rdata;
                    X_LEN:   x_reg <= len_word;
                    X_MSH:   x_reg <= {26'h0, pkt_val[3:0], 2'b00}; // 4*(P[k]&0xf)
                    default: x_reg <= a_reg; // tax
                endcase
            end
        end
    end

    // Offsets count from the following instruction
    assign pc_inc = pc + code_addr_t'(1);

    always_ff @(posedge clk) begin
        if (rst || dp_ctl.pc_clr) begin
            pc <= '0;
        end else if (dp_ctl.pc_en) begin
            case (dp_ctl.pc_sel)
                PC_NEXT: pc <= pc_inc;
                PC_JT:   pc <= pc_inc + code_addr_t'(insn_jt);
                PC_JF:   pc <= pc_inc + code_addr_t'(insn_jf);
                default: pc <= pc_inc + insn_k[CODE_ADDR_W-1:0]; // ja
            endcase
        end
    end

    assign alu_b = dp_ctl.b_sel_x ? x_reg : insn_k;

    bpf_alu u_alu (
        .clk    (clk),
        .rst    (rst),
        .a      (a_reg),
        .b      (alu_b),
        .op     (dp_ctl.alu_op),
        .en     (dp_ctl.alu_en),
        .result (alu_res),
        .eq     (alu_eq),
        .gt     (alu_gt),
        .ge     (alu_ge),
        .set    (alu_set),
        .vld    (alu_vld)
    );

    bpf_scratch u_scratch (
        .clk   (clk),
        .rst   (rst),
        .addr  (insn_k[3:0]),
        .wdata (dp_ctl.st_from_x ? x_reg : a_reg), // st or stx
        .we    (dp_ctl.st_en),
        .rdata (mem_rdata)
    );

    assign dp_stat = '{
        eq:      alu_eq,
        gt:      alu_gt,
        ge:      alu_ge,
        set:     alu_set,
        alu_vld: alu_vld,
        oob:     (end_addr > 34'(packet_len)),
        a_value: a_reg
    };

endmodule

// ==== hdl/bpf_scratch.sv ====
`timescale 1ns/1ps

module bpf_scratch import bpf_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] addr,
    input  word_t      wdata,
    input  logic       we,
    output word_t      rdata
);

    word_t mem [16]; // M[0..15]

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Read in the same cycle, no pipelining
    assign rdata = mem[addr];

endmodule

// ==== hdl/bpf_alu.sv ====
`timescale 1ns/1ps

module bpf_alu import bpf_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    input  logic    en,
    output word_t   result,
    output logic    eq,
    output logic    gt,
    output logic    ge,
    output logic    set,
    output logic    vld
);

    word_t res_d;
    logic  big_shift;

    // Shift counts of 32 and up flush the word
    assign big_shift = |b[31:5];

    always_comb begin
        case (op)
            ADD:     res_d = a + b;
            SUB:     res_d = a - b;
            MUL:     res_d = a * b;     // Low 32 bits only
            OR:      res_d = a | b;
            AND:     res_d = a & b;
            XOR:     res_d = a ^ b;
            LSH:     res_d = big_shift ? '0 : a << b[4:0];
            RSH:     res_d = big_shift ? '0 : a >> b[4:0];
            NEG:     res_d = -a;        // B ignored
            default: res_d = '0;
        endcase
    end

    // Result and flags held until the next strobe
    always_ff @(posedge clk) begin
        if (en) begin
            result <= res_d;
            eq     <= (a == b);
            gt     <= (a > b);  // Unsigned, as in BPF
            ge     <= (a >= b);
            set    <= |(a & b);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= 1'b0;
        end else begin
            vld <= en; // One cycle after the strobe
        end
    end

endmodule

// ==== hdl/bpf_pkg.sv ====
package bpf_pkg;

    localparam int CODE_ADDR_W = 8;  // Up to 256 instructions
    localparam int PKT_ADDR_W  = 12; // 4 KiB packet window

    typedef logic [31:0]            word_t;
    typedef logic [CODE_ADDR_W-1:0] code_addr_t;
    typedef logic [PKT_ADDR_W-1:0]  pkt_addr_t;
    typedef logic [PKT_ADDR_W:0]    pkt_len_t; // Extra bit so a full window fits

    // Classic BPF instruction, code in the top half
    typedef struct packed {
        logic [15:0] code;
        logic [7:0]  jt;
        logic [7:0]  jf;
        word_t       k;
    } bpf_insn_t;

    // Class field, code[2:0]
    localparam logic [2:0] CLS_LD   = 3'h0;
    localparam logic [2:0] CLS_LDX  = 3'h1;
    localparam logic [2:0] CLS_ST   = 3'h2;
    localparam logic [2:0] CLS_STX  = 3'h3;
    localparam logic [2:0] CLS_ALU  = 3'h4;
    localparam logic [2:0] CLS_JMP  = 3'h5;
    localparam logic [2:0] CLS_RET  = 3'h6;
    localparam logic [2:0] CLS_MISC = 3'h7;

    localparam logic [1:0] SZ_W = 2'h0; // Size field, code[4:3]
    localparam logic [1:0] SZ_H = 2'h1;
    localparam logic [1:0] SZ_B = 2'h2;

    // Mode field, code[7:5]
    localparam logic [2:0] MODE_IMM = 3'h0;
    localparam logic [2:0] MODE_ABS = 3'h1;
    localparam logic [2:0] MODE_IND = 3'h2;
    localparam logic [2:0] MODE_MEM = 3'h3;
    localparam logic [2:0] MODE_LEN = 3'h4;
    localparam logic [2:0] MODE_MSH = 3'h5;

    localparam logic SRC_K = 1'b0; // Operand source, code[3]
    localparam logic SRC_X = 1'b1;

    // Jump op, code[7:4]
    localparam logic [3:0] JMP_JA   = 4'h0;
    localparam logic [3:0] JMP_JEQ  = 4'h1;
    localparam logic [3:0] JMP_JGT  = 4'h2;
    localparam logic [3:0] JMP_JGE  = 4'h3;
    localparam logic [3:0] JMP_JSET = 4'h4;

    localparam logic [1:0] RVAL_K = 2'h0; // Return source, code[4:3]
    localparam logic [1:0] RVAL_A = 2'h2;

    localparam logic [4:0] MISC_TAX = 5'h00; // Misc op, code[7:3]
    localparam logic [4:0] MISC_TXA = 5'h10;

    // Encoded as the BPF op field, div and mod left out
    typedef enum logic [3:0] {
        ADD = 4'h0,
        SUB = 4'h1,
        MUL = 4'h2,
        OR  = 4'h4,
        AND = 4'h5,
        LSH = 4'h6,
        RSH = 4'h7,
        NEG = 4'h8,
        XOR = 4'ha
    } alu_op_e;

    typedef enum logic [2:0] {A_IMM, A_PKT, A_MEM, A_LEN, A_ALU, A_X} a_sel_e;
    typedef enum logic [2:0] {X_IMM, X_PKT, X_MEM, X_LEN, X_MSH, X_A} x_sel_e;
    typedef enum logic [1:0] {PC_NEXT, PC_JT, PC_JF, PC_K} pc_sel_e;

    typedef enum logic [2:0] {IDLE, FETCH, DECODE, PKT_WAIT, ALU_WAIT, DONE} ctl_state_e;

    // Controller commands to the datapath
    typedef struct packed {
        a_sel_e     a_sel;
        logic       a_en;
        x_sel_e     x_sel;
        logic       x_en;
        pc_sel_e    pc_sel;
        logic       pc_en;
        logic       pc_clr;
        logic       b_sel_x;   // ALU B from X, else K
        alu_op_e    alu_op;
        logic       alu_en;
        logic       st_en;
        logic       st_from_x; // Scratch write data from X, else A
        logic       addr_ind;  // Packet address X+k
        logic [1:0] load_size;
        logic       regs_clr;
    } dp_ctl_t;

    typedef struct packed {
        logic  eq;
        logic  gt;
        logic  ge;
        logic  set;
        logic  alu_vld;
        logic  oob;
        word_t a_value;
    } dp_stat_t;

endpackage
